// File: Bender.yml
package:
  name: raster_core

sources:
  - files:
      - rtl/raster_pkg.sv
      - rtl/raster_ctrl.sv
      - rtl/quad_counter.sv
      - rtl/edge_setup.sv
      - rtl/quad_eval.sv
      - rtl/raster_top.sv
  - target: simulation
    files:
      - bench/raster_tb.sv

// File: bench/raster_tb.sv
// ========================================
// Rasterizer core testbench
// Directed tests against a reference model
// of edge coverage, quad order and timing.
// ========================================

`timescale 1ns/1ps

module raster_tb import raster_pkg::*; ();

    localparam int TILE_LOGSIZE   = 3;
    localparam int TILE_SIDE      = 1 << TILE_LOGSIZE;
    localparam int QUADS          = (TILE_SIDE / 2) * (TILE_SIDE / 2);
    localparam int NUM_TILES      = 24;
    localparam int TIMEOUT_CYCLES = (QUADS + 4) * NUM_TILES + 10 + 100;

    logic                clk;
    logic                reset;
    logic                prim_valid;
    logic [DIM_BITS-1:0] tile_x;
    logic [DIM_BITS-1:0] tile_y;
    edge_coefs_t         edges;
    logic [PID_BITS-1:0] pid;
    logic                quad_valid;
    logic [DIM_BITS-1:0] quad_x;
    logic [DIM_BITS-1:0] quad_y;
    logic [3:0]          quad_mask;
    logic [PID_BITS-1:0] quad_pid;
    logic                done;
    logic                busy;

    int seed = 32'hf46f1496;
    int cycle_count = 0;

    // Expected quads of the current tile in output order
    int exp_x[$];
    int exp_y[$];
    int exp_mask[$];
    int exp_ofs[$];

    raster_top #(
        .TILE_LOGSIZE (TILE_LOGSIZE)
    ) raster_top_i (
        .clk        (clk),
        .reset      (reset),
        .prim_valid (prim_valid),
        .tile_x     (tile_x),
        .tile_y     (tile_y),
        .edges      (edges),
        .pid        (pid),
        .quad_valid (quad_valid),
        .quad_x     (quad_x),
        .quad_y     (quad_y),
        .quad_mask  (quad_mask),
        .quad_pid   (quad_pid),
        .done       (done),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after an error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    function automatic int rand_below(input int span);
        return ($random(seed) & 32'h7fffffff) % span;
    endfunction

    function automatic edge_coef_t make_edge(input int a, input int b, input int c);
        edge_coef_t e;
        e.a = coef_t'(a);
        e.b = coef_t'(b);
        e.c = coef_t'(c);
        return e;
    endfunction

    function automatic longint edge_value(input edge_coef_t e, input int x, input int y);
        return longint'(e.a) * x + longint'(e.b) * y + longint'(e.c);
    endfunction

    // A pixel counts when all three edges are non-negative
    task automatic build_expected(input int tx, input int ty, input edge_coefs_t e);
        logic [3:0] m;
        bit         covered;
        int         px;
        int         py;
        exp_x.delete();
        exp_y.delete();
        exp_mask.delete();
        exp_ofs.delete();
        for (int qy = 0; qy < TILE_SIDE / 2; qy++) begin
            for (int qx = 0; qx < TILE_SIDE / 2; qx++) begin
                m = 4'b0000;
                for (int p = 0; p < 4; p++) begin
                    px = tx + 2 * qx + (p % 2);
                    py = ty + 2 * qy + (p / 2);
                    covered = 1'b1;
                    for (int i = 0; i < 3; i++) begin
                        if (edge_value(e[i], px, py) < 0) begin
                            covered = 1'b0;
                        end
                    end
                    m[p] = covered;
                end
                if (m != 4'b0000) begin
                    exp_x.push_back(tx + 2 * qx);
                    exp_y.push_back(ty + 2 * qy);
                    exp_mask.push_back(m);
                    // Quad k leaves three cycles after the strobe plus k
                    exp_ofs.push_back(3 + qy * (TILE_SIDE / 2) + qx);
                end
            end
        end
    endtask

    // Sends one primitive and optionally a second strobe extra_cyc cycles later
    task automatic run_tile(input int tx, input int ty, input edge_coefs_t e,
                            input logic [PID_BITS-1:0] p, input int extra_cyc,
                            input logic [PID_BITS-1:0] extra_pid);
        int cyc;
        bit got_done;
        build_expected(tx, ty, e);
        tile_x     = DIM_BITS'(tx);
        tile_y     = DIM_BITS'(ty);
        edges      = e;
        pid        = p;
        prim_valid = 1'b1;
        cyc        = 0;
        got_done   = 1'b0;
        while (!got_done) begin
            @(posedge clk);
            #1;
            cyc++;
            prim_valid = (extra_cyc != 0) && (cyc == extra_cyc);
            if (prim_valid) begin
                pid = extra_pid;
            end
            check_value("busy", busy, 1);
            if (quad_valid) begin
                if (exp_x.size() == 0) begin
                    $display("Error at %0t ns: a quad strobe came with no quad left to expect",
                             $time);
                    stop_run();
                end else begin
                    check_value("quad_x", quad_x, exp_x.pop_front());
                    check_value("quad_y", quad_y, exp_y.pop_front());
                    check_value("quad_mask", quad_mask, exp_mask.pop_front());
                    check_value("quad_pid", quad_pid, p);
                    check_value("quad cycle", cyc, exp_ofs.pop_front());
                end
            end
            if (done) begin
                check_value("done cycle", cyc, QUADS + 3);
                check_value("quads left at done", exp_x.size(), 0);
                got_done = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        check_value("busy", busy, 0);
        check_value("done", done, 0);
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_value("quad_valid", quad_valid, 0);
            check_value("done", done, 0);
            check_value("busy", busy, 0);
        end
    endtask

    task automatic test_idle_after_reset();
        watch_idle(5);
    endtask

    task automatic test_full_coverage();
        edge_coefs_t e;
        for (int i = 0; i < 3; i++) begin
            e[i] = make_edge(0, 0, 5);
        end
        run_tile(16, 8, e, 8'h21, 0, 8'h00);
    endtask

    task automatic test_empty_tile();
        edge_coefs_t e;
        e[0] = make_edge(0, 0, 3);
        e[1] = make_edge(0, 0, -1);
        e[2] = make_edge(0, 0, 3);
        run_tile(0, 0, e, 8'h33, 0, 8'h00);
    endtask

    task automatic test_diagonal_half_plane();
        edge_coefs_t e;
        // x - y - 16 passes through the tile corner at (40, 24)
        e[0] = make_edge(1, -1, -16);
        e[1] = make_edge(0, 0, 1);
        e[2] = make_edge(0, 0, 1);
        run_tile(40, 24, e, 8'h44, 0, 8'h00);
    endtask

    task automatic test_random_triangles();
        edge_coefs_t e;
        int          tx;
        int          ty;
        int          vx[3];
        int          vy[3];
        int          a[3];
        int          b[3];
        int          c[3];
        int          j1;
        for (int t = 0; t < 20; t++) begin
            tx = rand_below(8) * TILE_SIDE;
            ty = rand_below(8) * TILE_SIDE;
            for (int j = 0; j < 3; j++) begin
                vx[j] = tx + rand_below(16) - 4;
                vy[j] = ty + rand_below(16) - 4;
            end
            for (int j = 0; j < 3; j++) begin
                j1   = (j + 1) % 3;
                a[j] = vy[j] - vy[j1];
                b[j] = vx[j1] - vx[j];
                c[j] = vx[j] * vy[j1] - vx[j1] * vy[j];
            end
            // Flip clockwise triangles so the inside is non-negative
            if (a[0] * vx[2] + b[0] * vy[2] + c[0] < 0) begin
                for (int j = 0; j < 3; j++) begin
                    a[j] = -a[j];
                    b[j] = -b[j];
                    c[j] = -c[j];
                end
            end
            for (int j = 0; j < 3; j++) begin
                e[j] = make_edge(a[j], b[j], c[j]);
            end
            run_tile(tx, ty, e, PID_BITS'(rand_below(256)), 0, 8'h00);
        end
    endtask

    task automatic test_busy_strobe_ignored();
        edge_coefs_t e;
        e[0] = make_edge(-1, 1, 2);
        e[1] = make_edge(0, 0, 1);
        e[2] = make_edge(0, 0, 1);
        run_tile(8, 32, e, 8'h5a, 2, 8'ha5);
        watch_idle(4);
    endtask

    initial begin
        reset      = 1'b1;
        prim_valid = 1'b0;
        tile_x     = '0;
        tile_y     = '0;
        edges      = '0;
        pid        = '0;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_idle_after_reset();
        test_full_coverage();
        test_empty_tile();
        test_diagonal_half_plane();
        test_random_triangles();
        test_busy_strobe_ignored();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: rtl/edge_setup.sv
// ========================================
// Edge setup
// Captures an accepted primitive and
// evaluates its three edge functions at
// the tile origin during the setup cycle.
// ========================================

`timescale 1ns/1ps

module edge_setup import raster_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    input  logic                accept,
    input  logic                setup_en,

    input  logic [DIM_BITS-1:0] tile_x,
    input  logic [DIM_BITS-1:0] tile_y,
    input  edge_coefs_t         edges,
    input  logic [PID_BITS-1:0] pid,

    output edge_coefs_t         coefs,
    output edge_vals_t          origin_vals,
    output logic [DIM_BITS-1:0] origin_x,
    output logic [DIM_BITS-1:0] origin_y,
    output logic [PID_BITS-1:0] prim_pid
);

    edge_vals_t org_eval;
    eval_t      org_x;
    eval_t      org_y;

    // Coordinates are unsigned, zero extension keeps them positive
    assign org_x = EVAL_BITS'(origin_x);
    assign org_y = EVAL_BITS'(origin_y);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            org_eval[i] = EVAL_BITS'(coefs[i].a) * org_x
                        + EVAL_BITS'(coefs[i].b) * org_y
                        + EVAL_BITS'(coefs[i].c);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            coefs    <= edges;
            origin_x <= tile_x;
            origin_y <= tile_y;
            prim_pid <= pid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            origin_vals <= '0;
        end else if (setup_en) begin
            origin_vals <= org_eval;
        end
    end

endmodule

// File: rtl/quad_counter.sv
// ========================================
// Quad counter
// Walks 2x2 quad offsets across the tile
// in row-major order, flags the last quad.
// ========================================

`timescale 1ns/1ps

module quad_counter #(
    parameter int TILE_LOGSIZE = 3
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    setup_en,
    input  logic                    scan_en,

    output logic [TILE_LOGSIZE-1:0] quad_dx,
    output logic [TILE_LOGSIZE-1:0] quad_dy,
    output logic                    last_quad
);

    // Offset of the last quad along either axis
    localparam logic [TILE_LOGSIZE-1:0] LAST_OFS = TILE_LOGSIZE'((1 << TILE_LOGSIZE) - 2);
    localparam logic [TILE_LOGSIZE-1:0] STEP     = TILE_LOGSIZE'(2);

    logic row_end;

    assign row_end   = (quad_dx == LAST_OFS);
    assign last_quad = row_end && (quad_dy == LAST_OFS);

    always_ff @(posedge clk) begin
        if (reset || setup_en) begin
            quad_dx <= '0;
            quad_dy <= '0;
        end else if (scan_en) begin
            if (row_end) begin
                quad_dx <= '0;
                quad_dy <= quad_dy + STEP;
            end else begin
                quad_dx <= quad_dx + STEP;
            end
        end
    end

endmodule

// File: rtl/quad_eval.sv
// ========================================
// Quad evaluator
// Steps the origin edge values to the four
// pixels of the current quad, builds the
// coverage mask and registers the output.
// ========================================

`timescale 1ns/1ps

module quad_eval import raster_pkg::*; #(
    parameter int TILE_LOGSIZE = 3
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    scan_en,
    input  logic [TILE_LOGSIZE-1:0] quad_dx,
    input  logic [TILE_LOGSIZE-1:0] quad_dy,

    input  edge_coefs_t             coefs,
    input  edge_vals_t              origin_vals,
    input  logic [DIM_BITS-1:0]     origin_x,
    input  logic [DIM_BITS-1:0]     origin_y,
    input  logic [PID_BITS-1:0]     prim_pid,

    output logic                    quad_valid,
    output logic [DIM_BITS-1:0]     quad_x,
    output logic [DIM_BITS-1:0]     quad_y,
    output logic [3:0]              quad_mask,
    output logic [PID_BITS-1:0]     quad_pid
);

    logic [3:0] mask;

    // Pixel p sits at (dx + p%2, dy + p/2), matching the mask bit order
    always_comb begin
        eval_t pix_x;
        eval_t pix_y;
        eval_t val;
        logic  covered;

        for (int p = 0; p < 4; p++) begin
            pix_x   = EVAL_BITS'(quad_dx) + EVAL_BITS'(p % 2);
            pix_y   = EVAL_BITS'(quad_dy) + EVAL_BITS'(p / 2);
            covered = 1'b1;
            for (int i = 0; i < 3; i++) begin
                val = origin_vals[i]
                    + EVAL_BITS'(coefs[i].a) * pix_x
                    + EVAL_BITS'(coefs[i].b) * pix_y;
                // Inside when non-negative
                covered = covered && !val[EVAL_BITS-1];
            end
            mask[p] = covered;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            quad_valid <= 1'b0;
        end else begin
            quad_valid <= scan_en && (mask != 4'b0000);
        end
    end

    always_ff @(posedge clk) begin
        if (scan_en) begin
            quad_x    <= origin_x + DIM_BITS'(quad_dx);
            quad_y    <= origin_y + DIM_BITS'(quad_dy);
            quad_mask <= mask;
            quad_pid  <= prim_pid;
        end
    end

endmodule

// File: rtl/raster_ctrl.sv
// ========================================
// Raster controller
// Accepts a primitive while idle, runs one
// setup cycle, scans the tile quad by quad
// and raises done after the last output.
// ========================================

`timescale 1ns/1ps

module raster_ctrl import raster_pkg::*; (
    input  logic clk,
    input  logic reset,

    input  logic prim_valid,
    input  logic last_quad,

    output logic accept,
    output logic setup_en,
    output logic scan_en,
    output logic busy,
    output logic done
);

    ctrl_state_t state;

    // A strobe while busy is dropped
    assign accept = prim_valid && !busy;

    assign setup_en = (state == SETUP);
    assign scan_en  = (state == SCAN);

    // Done covers the slot after FINISH, so busy holds through it
    assign busy = (state != IDLE) || done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            // Lines up with the final quad output
            done <= (state == FINISH);

            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    state <= SCAN;
                end
                SCAN: begin
                    if (last_quad) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/raster_pkg.sv
// ========================================
// Raster package
// Widths, edge coefficient and edge value
// types, and the controller state encoding
// for the single-tile rasterizer core.
// ========================================

package raster_pkg;

    // Signed edge coefficient width
    localparam int DATA_BITS = 16;

    // Unsigned pixel coordinate width
    localparam int DIM_BITS = 16;

    localparam int PID_BITS = 8;

    // Holds a*x + b*y + c without overflow
    localparam int EVAL_BITS = 34;

    typedef logic signed [DATA_BITS-1:0] coef_t;

    typedef logic signed [EVAL_BITS-1:0] eval_t;

    // One edge evaluates to a*x + b*y + c
    typedef struct packed {
        coef_t a;
        coef_t b;
        coef_t c;
    } edge_coef_t;

    // Three edges of a primitive
    typedef edge_coef_t [2:0] edge_coefs_t;

    // One edge function value per edge
    typedef eval_t [2:0] edge_vals_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        SCAN,
        FINISH
    } ctrl_state_t;

endpackage

// File: rtl/raster_top.sv
// ========================================
// Rasterizer core top level
// Scans one tile per primitive and emits
// covered 2x2 quads, then a done strobe.
// ========================================

`timescale 1ns/1ps

module raster_top import raster_pkg::*; #(
    parameter int TILE_LOGSIZE = 3
) (
    input  logic                clk,
    input  logic                reset,

    input  logic                prim_valid,
    input  logic [DIM_BITS-1:0] tile_x,
    input  logic [DIM_BITS-1:0] tile_y,
    input  edge_coefs_t         edges,
    input  logic [PID_BITS-1:0] pid,

    output logic                quad_valid,
    output logic [DIM_BITS-1:0] quad_x,
    output logic [DIM_BITS-1:0] quad_y,
    output logic [3:0]          quad_mask,
    output logic [PID_BITS-1:0] quad_pid,
    output logic                done,
    output logic                busy
);

    logic                    accept;
    logic                    setup_en;
    logic                    scan_en;
    logic                    last_quad;
    logic [TILE_LOGSIZE-1:0] quad_dx;
    logic [TILE_LOGSIZE-1:0] quad_dy;

    edge_coefs_t             coefs;
    edge_vals_t              origin_vals;
    logic [DIM_BITS-1:0]     origin_x;
    logic [DIM_BITS-1:0]     origin_y;
    logic [PID_BITS-1:0]     prim_pid;

    raster_ctrl raster_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .prim_valid (prim_valid),
        .last_quad  (last_quad),
        .accept     (accept),
        .setup_en   (setup_en),
        .scan_en    (scan_en),
        .busy       (busy),
        .done       (done)
    );

    quad_counter #(
        .TILE_LOGSIZE (TILE_LOGSIZE)
    ) quad_counter_i (
        .clk       (clk),
        .reset     (reset),
        .setup_en  (setup_en),
        .scan_en   (scan_en),
        .quad_dx   (quad_dx),
        .quad_dy   (quad_dy),
        .last_quad (last_quad)
    );

    edge_setup edge_setup_i (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .setup_en    (setup_en),
        .tile_x      (tile_x),
        .tile_y      (tile_y),
        .edges       (edges),
        .pid         (pid),
        .coefs       (coefs),
        .origin_vals (origin_vals),
        .origin_x    (origin_x),
        .origin_y    (origin_y),
        .prim_pid    (prim_pid)
    );

    quad_eval #(
        .TILE_LOGSIZE (TILE_LOGSIZE)
    ) quad_eval_i (
        .clk         (clk),
        .reset       (reset),
        .scan_en     (scan_en),
        .quad_dx     (quad_dx),
        .quad_dy     (quad_dy),
        .coefs       (coefs),
        .origin_vals (origin_vals),
        .origin_x    (origin_x),
        .origin_y    (origin_y),
        .prim_pid    (prim_pid),
        .quad_valid  (quad_valid),
        .quad_x      (quad_x),
        .quad_y      (quad_y),
        .quad_mask   (quad_mask),
        .quad_pid    (quad_pid)
    );

endmodule

// File: sim.f
rtl/raster_pkg.sv
rtl/raster_ctrl.sv
rtl/quad_counter.sv
rtl/edge_setup.sv
rtl/quad_eval.sv
rtl/raster_top.sv
bench/raster_tb.sv
